// File: list.f
+incdir+common
common/mmu_pkg.sv
hdl/satp_regs.sv
hdl/dtlb.sv
ptw/ptw.sv
hdl/mmu_ctrl.sv
hdl/mmu_top.sv
tb/pt_mem.sv
tb/tb_mmu_top.sv

// File: Bender.yml
package:
  name: sv32_dmmu

sources:
  - include_dirs:
      - common
    files:
      - common/mmu_pkg.sv
      - hdl/satp_regs.sv
      - hdl/dtlb.sv
      - ptw/ptw.sv
      - hdl/mmu_ctrl.sv
      - hdl/mmu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/pt_mem.sv
      - tb/tb_mmu_top.sv

// File: tb/tb_mmu_top.sv
// Testbench for the data MMU covering bare mode, page walks, TLB hits, faults and flushes.
// Top module tb_mmu_top, compiled with list.f from the project root.
`timescale 1ns/100ps
`include "mmu_config.svh"

module tb_mmu_top
    import mmu_pkg::*;
();

    // Fixed page table
    localparam ppn_t              ROOT_PPN   = 20'h00001;
    localparam ppn_t              L0_PPN     = 20'h00002;
    localparam logic [`VPN_W-1:0] SUPER_VPN1 = 10'h040;
    localparam ppn_t              SUPER_PPN  = 20'h23400;
    localparam logic [`VPN_W-1:0] PAGE_VPN1  = 10'h081;
    localparam logic [`VPN_W-1:0] PAGE_VPN0  = 10'h005;
    localparam ppn_t              PAGE_PPN   = 20'h5a5a5;
    localparam logic [`VPN_W-1:0] BAD_VPN1   = 10'h0c2;
    // About 25 accesses of at most ten cycles each and a wide margin on top
    localparam int                TIMEOUT_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        satp_we;
    logic [31:0] satp_wdata;
    logic        sfence;
    logic        req;
    logic [31:0] vaddr;
    logic        busy;
    logic        done;
    logic        fault;
    logic [31:0] paddr;
    logic        mem_rd;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic        mem_rvalid;

    // Reference copy of the page-table memory
    pte_t        ref_mem [4096];
    ppn_t        cur_root = '0;
    bit          xlate_on = 1'b0;
    logic [31:0] rng = 32'h645a;
    logic [31:0] rd_addrs [$];
    logic        done_seen = 1'b0;
    int          cycle_count = 0;

    mmu_top mmu_top_inst (
        .clk, .rst_n, .satp_we, .satp_wdata, .sfence,
        .req, .vaddr, .busy, .done, .fault, .paddr,
        .mem_rd, .mem_addr, .mem_rdata, .mem_rvalid
    );

    pt_mem pt_mem_inst (
        .clk, .rst_n, .mem_rd, .mem_addr, .mem_rdata, .mem_rvalid
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("FAILED %s: %s expected %h actual %h",
                               name, what, expected, actual));
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pte_t make_pte(input ppn_t ppn, input bit v, input bit r,
                                      input bit w, input bit x);
        pte_t p;
        p = '0;
        p[`PTE_PPN_LSB+`PPN_W-1:`PTE_PPN_LSB] = ppn;
        p[`PTE_V] = v;
        p[`PTE_R] = r;
        p[`PTE_W] = w;
        p[`PTE_X] = x;
        return p;
    endfunction

    // Addresses in the mapped regions picked from one random word
    function automatic logic [31:0] page_va(input logic [31:0] r);
        return {PAGE_VPN1, PAGE_VPN0, r[23:12]};
    endfunction

    function automatic logic [31:0] super_va(input logic [31:0] r);
        return {SUPER_VPN1, r[29:20], r[23:12]};
    endfunction

    task automatic put_pte(input logic [31:0] addr, input pte_t pte);
        ref_mem[addr[13:2]] = pte;
        pt_mem_inst.mem[addr[13:2]] = pte;
    endtask

    task automatic load_tables();
        // Background words all have V clear
        for (int i = 0; i < 4096; i++) begin
            put_pte({i[29:0], 2'b00}, {~i[11:0], i[11:0], 8'hf0});
        end
        put_pte({ROOT_PPN, SUPER_VPN1, 2'b00}, make_pte(SUPER_PPN, 1, 1, 1, 0));
        // Pointer to the level-0 table
        put_pte({ROOT_PPN, PAGE_VPN1, 2'b00}, make_pte(L0_PPN, 1, 0, 0, 0));
        put_pte({L0_PPN, PAGE_VPN0, 2'b00}, make_pte(PAGE_PPN, 1, 1, 1, 0));
        // R and W set but not valid
        put_pte({ROOT_PPN, BAD_VPN1, 2'b00}, make_pte(20'h00777, 0, 1, 1, 0));
    endtask

    // Sv32 walk over the reference table
    task automatic ref_walk(input logic [31:0] va, output logic [31:0] pa, output logic f,
                            output int reads, output logic [31:0] a1, output logic [31:0] a0);
        pte_t pte1;
        pte_t pte0;
        pa    = '0;
        f     = 1'b0;
        a0    = '0;
        a1    = {cur_root, va[31:22], 2'b00};
        pte1  = ref_mem[a1[13:2]];
        reads = 1;
        if (!pte1[`PTE_V]) begin
            f = 1'b1;
        end else if (pte1[`PTE_R] || pte1[`PTE_X]) begin
            // Superpage keeps VPN[0] of the virtual address
            pa = {pte1[`PTE_PPN_LSB+`PPN_W-1:`PTE_PPN_LSB+`VPN_W], va[21:0]};
        end else begin
            a0    = {pte1[`PTE_PPN_LSB+`PPN_W-1:`PTE_PPN_LSB], va[21:12], 2'b00};
            pte0  = ref_mem[a0[13:2]];
            reads = 2;
            if (!pte0[`PTE_V] || !(pte0[`PTE_R] || pte0[`PTE_X])) begin
                f = 1'b1;
            end else begin
                pa = {pte0[`PTE_PPN_LSB+`PPN_W-1:`PTE_PPN_LSB], va[11:0]};
            end
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic write_satp(input logic [31:0] value);
        satp_wdata = value;
        satp_we    = 1'b1;
        step();
        satp_we  = 1'b0;
        xlate_on = value[31];
        cur_root = value[`PPN_W-1:0];
        // Wait out the flush pulse and the cleared valid bits
        repeat (2) step();
    endtask

    task automatic pulse_sfence();
        sfence = 1'b1;
        step();
        sfence = 1'b0;
        repeat (2) step();
    endtask

    // One request where cached marks an expected TLB hit
    task automatic run_access(input string name, input logic [31:0] va, input bit cached);
        logic [31:0] exp_pa;
        logic [31:0] exp_a1;
        logic [31:0] exp_a0;
        logic        exp_fault;
        int          exp_reads;
        int          lat;
        if (xlate_on) begin
            ref_walk(va, exp_pa, exp_fault, exp_reads, exp_a1, exp_a0);
        end else begin
            exp_pa    = va;
            exp_fault = 1'b0;
            exp_reads = 0;
            exp_a1    = '0;
            exp_a0    = '0;
        end
        if (cached) begin
            exp_reads = 0;
        end
        rd_addrs.delete();
        check_value(name, "busy before request", 32'd0, busy);
        req   = 1'b1;
        vaddr = va;
        lat   = 0;
        do begin
            step();
            req = 1'b0;
            lat++;
        end while (!done);
        check_value(name, "busy at done", 32'd1, busy);
        if (!xlate_on || cached) begin
            check_value(name, "latency", 32'd1, lat);
        end
        check_value(name, "fault", exp_fault, fault);
        if (!exp_fault) begin
            check_value(name, "paddr", exp_pa, paddr);
        end
        check_value(name, "memory reads", exp_reads, rd_addrs.size());
        if (exp_reads > 0) begin
            check_value(name, "level-1 address", exp_a1, rd_addrs[0]);
        end
        if (exp_reads > 1) begin
            check_value(name, "level-0 address", exp_a0, rd_addrs[1]);
        end
        // Sequencer back to idle
        step();
    endtask

    // Memory port and done pulse monitor at mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_rd) begin
                rd_addrs.push_back(mem_addr);
            end
            assert (!mem_rd || busy) else
                fail_run("Memory read issued while the MMU was idle");
            assert (!(done && done_seen)) else
                fail_run("done stayed high for more than one cycle");
            done_seen = done;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        logic [31:0] bad_va;
        rst_n      = 1'b0;
        satp_we    = 1'b0;
        satp_wdata = '0;
        sfence     = 1'b0;
        req        = 1'b0;
        vaddr      = '0;
        load_tables();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();
        check_value("reset", "done", 32'd0, done);
        check_value("reset", "busy", 32'd0, busy);
        check_value("reset", "mem_rd", 32'd0, mem_rd);

        // Bare mode passes addresses through
        repeat (3) begin
            rng = lcg_step(rng);
            run_access("bare", rng, 1'b0);
        end

        write_satp({1'b1, 11'b0, ROOT_PPN});
        rng = lcg_step(rng);
        run_access("page walk", page_va(rng), 1'b0);
        rng = lcg_step(rng);
        run_access("superpage walk", super_va(rng), 1'b0);

        // Cached pages with other offsets and other pages of the superpage
        repeat (6) begin
            rng = lcg_step(rng);
            run_access("page hit", page_va(rng), 1'b1);
            rng = lcg_step(rng);
            run_access("superpage hit", super_va(rng), 1'b1);
        end

        // Faults are not cached so the repeat walks again
        rng    = lcg_step(rng);
        bad_va = {BAD_VPN1, rng[29:8]};
        run_access("fault walk", bad_va, 1'b0);
        run_access("fault repeat", bad_va, 1'b0);

        pulse_sfence();
        rng = lcg_step(rng);
        run_access("page after sfence", page_va(rng), 1'b0);
        rng = lcg_step(rng);
        run_access("page hit after refill", page_va(rng), 1'b1);
        rng = lcg_step(rng);
        run_access("superpage after sfence", super_va(rng), 1'b0);

        // Same satp again still flushes
        write_satp({1'b1, 11'b0, ROOT_PPN});
        rng = lcg_step(rng);
        run_access("superpage after satp write", super_va(rng), 1'b0);
        rng = lcg_step(rng);
        run_access("page after satp write", page_va(rng), 1'b0);
        rng = lcg_step(rng);
        run_access("superpage hit after refill", super_va(rng), 1'b1);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tb/pt_mem.sv
// Page-table memory model for the MMU testbench.
// Answers each read strobe two cycles later from a word array the testbench preloads.
`timescale 1ns/100ps

module pt_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_rd,
    input  logic [31:0] mem_addr,
    output logic [31:0] mem_rdata,
    output logic        mem_rvalid
);

    // 16 KiB of words, written directly by the testbench
    logic [31:0] mem [4096];

    logic        rd_q;
    logic [11:0] idx_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q       <= 1'b0;
            idx_q      <= '0;
            mem_rvalid <= 1'b0;
            mem_rdata  <= '0;
        end else begin
            // First cycle of the delay, hold the word index
            rd_q <= mem_rd;
            if (mem_rd) begin
                idx_q <= mem_addr[13:2];
            end
            // Second cycle, return the data
            mem_rvalid <= rd_q;
            mem_rdata  <= mem[idx_q];
        end
    end

endmodule

// File: hdl/mmu_top.sv
// Data-side Sv32 MMU top, joins satp registers, sequencer, TLB and walker.
`timescale 1ns/100ps
`include "mmu_config.svh"

module mmu_top
    import mmu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        satp_we,
    input  logic [31:0] satp_wdata,
    input  logic        sfence,
    input  logic        req,
    input  logic [31:0] vaddr,
    output logic        busy,
    output logic        done,
    output logic        fault,
    output logic [31:0] paddr,
    output logic        mem_rd,
    output logic [31:0] mem_addr,
    input  logic [31:0] mem_rdata,
    input  logic        mem_rvalid
);

    logic                xlate_en;
    ppn_t                root_ppn;
    logic                tlb_flush;
    logic [2*`VPN_W-1:0] lookup_vpn;
    logic                hit;
    pte_t                hit_pte;
    logic                hit_super;
    logic                walk_start;
    logic                walk_done;
    pte_t                walk_pte;
    logic                walk_super;
    logic                walk_fault;
    logic                tlb_update;
    logic [2*`VPN_W-1:0] upd_vpn;
    pte_t                upd_pte;
    logic                upd_super;

    satp_regs satp_regs_inst (
        .clk, .rst_n, .satp_we, .satp_wdata, .sfence,
        .xlate_en, .root_ppn, .tlb_flush
    );

    mmu_ctrl mmu_ctrl_inst (
        .clk, .rst_n, .req, .vaddr, .busy, .done, .fault, .paddr,
        .xlate_en, .lookup_vpn, .hit, .hit_pte, .hit_super,
        .walk_start, .walk_done, .walk_pte, .walk_super, .walk_fault
    );

    dtlb dtlb_inst (
        .clk, .rst_n, .lookup_vpn, .hit, .hit_pte, .hit_super,
        .tlb_update, .upd_vpn, .upd_pte, .upd_super, .tlb_flush
    );

    // Walk VPN is the latched request VPN shown on the lookup port
    ptw ptw_inst (
        .clk, .rst_n, .walk_start, .walk_vpn(lookup_vpn), .root_ppn,
        .walk_done, .walk_pte, .walk_super, .walk_fault,
        .tlb_update, .upd_vpn, .upd_pte, .upd_super,
        .mem_rd, .mem_addr, .mem_rdata, .mem_rvalid
    );

endmodule

// File: hdl/mmu_ctrl.sv
// Request sequencer of the data MMU.
// Picks bare, TLB hit, walk or fault and registers the response.
`timescale 1ns/100ps
`include "mmu_config.svh"

module mmu_ctrl
    import mmu_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  logic [31:0]         vaddr,
    output logic                busy,
    output logic                done,
    output logic                fault,
    output logic [31:0]         paddr,
    input  logic                xlate_en,
    output logic [2*`VPN_W-1:0] lookup_vpn,
    input  logic                hit,
    input  pte_t                hit_pte,
    input  logic                hit_super,
    output logic                walk_start,
    input  logic                walk_done,
    input  pte_t                walk_pte,
    input  logic                walk_super,
    input  logic                walk_fault
);

    ctrl_state_e state;
    logic [31:0] vaddr_q;

    // Leaf PPN joined with the page offset
    // Superpages also keep VPN[0] of the address
    function automatic logic [31:0] form_paddr(pte_t pte, logic is_super, logic [31:0] va);
        ppn_t ppn;
        ppn = pte[`PTE_PPN_LSB+`PPN_W-1:`PTE_PPN_LSB];
        if (is_super) begin
            return {ppn[`PPN_W-1:`VPN_W], va[`PAGE_OFS_W+`VPN_W-1:0]};
        end
        return {ppn, va[`PAGE_OFS_W-1:0]};
    endfunction

    // Request cycle looks up the live address
    // Later states use the latched one, which also feeds the walker
    assign lookup_vpn = (state == CTRL_IDLE) ? vaddr[31:`PAGE_OFS_W] : vaddr_q[31:`PAGE_OFS_W];

    assign busy       = (state != CTRL_IDLE);
    assign done       = (state == CTRL_RESP);
    assign walk_start = (state == CTRL_LOOKUP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
            fault <= 1'b0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (req) begin
                        vaddr_q <= vaddr;
                        if (!xlate_en) begin
                            // Bare mode passes the address through
                            paddr <= vaddr;
                            fault <= 1'b0;
                            state <= CTRL_RESP;
                        end else if (hit) begin
                            paddr <= form_paddr(hit_pte, hit_super, vaddr);
                            fault <= 1'b0;
                            state <= CTRL_RESP;
                        end else begin
                            state <= CTRL_LOOKUP;
                        end
                    end
                end
                // Miss starts the walker
                CTRL_LOOKUP: state <= CTRL_WALK;
                CTRL_WALK: begin
                    if (walk_done) begin
                        // Take the PTE straight from the walker
                        paddr <= form_paddr(walk_pte, walk_super, vaddr_q);
                        fault <= walk_fault;
                        state <= CTRL_RESP;
                    end
                end
                CTRL_RESP: state <= CTRL_IDLE;
                default:   state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

// File: ptw/ptw.sv
// Two-level Sv32 page-table walker for the data TLB.
// Reads PTEs one at a time over the memory read port and refills the TLB.
`timescale 1ns/100ps
`include "mmu_config.svh"

module ptw
    import mmu_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                walk_start,
    input  logic [2*`VPN_W-1:0] walk_vpn,
    input  ppn_t                root_ppn,
    output logic                walk_done,
    output pte_t                walk_pte,
    output logic                walk_super,
    output logic                walk_fault,
    output logic                tlb_update,
    output logic [2*`VPN_W-1:0] upd_vpn,
    output pte_t                upd_pte,
    output logic                upd_super,
    output logic                mem_rd,
    output logic [31:0]         mem_addr,
    input  logic [31:0]         mem_rdata,
    input  logic                mem_rvalid
);

    ptw_state_e state;

    logic [2*`VPN_W-1:0] vpn_q;
    // Table base for the current level
    ppn_t                base_q;
    pte_t                pte_q;
    logic                super_q;
    logic                fault_q;

    logic                rd_valid;
    logic                rd_leaf;
    ppn_t                rd_ppn;
    logic [`VPN_W-1:0]   vpn_sel;

    // Decode the returned PTE
    assign rd_valid = mem_rdata[`PTE_V];
    assign rd_leaf  = mem_rdata[`PTE_R] | mem_rdata[`PTE_X];
    assign rd_ppn   = mem_rdata[`PTE_PPN_LSB+`PPN_W-1:`PTE_PPN_LSB];

    // VPN[1] indexes the root table, VPN[0] the second level
    assign vpn_sel  = (state == PTW_L0_REQ) ? vpn_q[`VPN_W-1:0] : vpn_q[2*`VPN_W-1:`VPN_W];
    assign mem_addr = {base_q, vpn_sel, 2'b00};
    assign mem_rd   = (state == PTW_L1_REQ) || (state == PTW_L0_REQ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PTW_IDLE;
        end else begin
            case (state)
                PTW_IDLE: begin
                    if (walk_start) begin
                        state <= PTW_L1_REQ;
                    end
                end
                PTW_L1_REQ: state <= PTW_L1_WAIT;
                PTW_L1_WAIT: begin
                    if (mem_rvalid) begin
                        // Invalid entry or superpage leaf ends the walk here
                        if (!rd_valid || rd_leaf) begin
                            state <= PTW_DONE;
                        end else begin
                            state <= PTW_L0_REQ;
                        end
                    end
                end
                PTW_L0_REQ: state <= PTW_L0_WAIT;
                PTW_L0_WAIT: begin
                    if (mem_rvalid) begin
                        state <= PTW_DONE;
                    end
                end
                PTW_DONE: state <= PTW_IDLE;
                default:  state <= PTW_IDLE;
            endcase
        end
    end

    // Walk context and result
    always_ff @(posedge clk) begin
        if (state == PTW_IDLE && walk_start) begin
            vpn_q  <= walk_vpn;
            base_q <= root_ppn;
        end
        if (state == PTW_L1_WAIT && mem_rvalid) begin
            pte_q   <= mem_rdata;
            super_q <= rd_leaf;
            fault_q <= !rd_valid;
            // Pointer entry, follow it to level 0
            base_q  <= rd_ppn;
        end
        if (state == PTW_L0_WAIT && mem_rvalid) begin
            pte_q   <= mem_rdata;
            super_q <= 1'b0;
            // Level 0 must hold a leaf
            fault_q <= !rd_valid || !rd_leaf;
        end
    end

    assign walk_done  = (state == PTW_DONE);
    assign walk_pte   = pte_q;
    assign walk_super = super_q;
    assign walk_fault = fault_q;

    // Refill in the done cycle, faults are never cached
    assign tlb_update = walk_done && !fault_q;
    assign upd_vpn    = vpn_q;
    assign upd_pte    = pte_q;
    assign upd_super  = super_q;

endmodule

// File: hdl/dtlb.sv
// Direct-mapped data TLB, combinational lookup with refill and flush-all.
// Indexed by the low bits of VPN[1] so a superpage fills a single slot.
`timescale 1ns/100ps
`include "mmu_config.svh"

module dtlb
    import mmu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [2*`VPN_W-1:0]  lookup_vpn,
    output logic                 hit,
    output pte_t                 hit_pte,
    output logic                 hit_super,
    input  logic                 tlb_update,
    input  logic [2*`VPN_W-1:0]  upd_vpn,
    input  pte_t                 upd_pte,
    input  logic                 upd_super,
    input  logic                 tlb_flush
);

    // Entry storage
    logic [`DTLB_ENTRIES-1:0] valid_q;
    logic [`VPN_W-1:0]        vpn1_q  [`DTLB_ENTRIES];
    logic [`VPN_W-1:0]        vpn0_q  [`DTLB_ENTRIES];
    logic                     super_q [`DTLB_ENTRIES];
    pte_t                     pte_q   [`DTLB_ENTRIES];

    logic [`DTLB_WIDTH-1:0] r_index;
    logic [`DTLB_WIDTH-1:0] w_index;
    logic [`VPN_W-1:0]      lk_vpn1;
    logic [`VPN_W-1:0]      lk_vpn0;

    // Split the looked-up VPN into its two Sv32 fields
    assign lk_vpn1 = lookup_vpn[2*`VPN_W-1:`VPN_W];
    assign lk_vpn0 = lookup_vpn[`VPN_W-1:0];

    // Both ports index with the low bits of VPN[1]
    assign r_index = lookup_vpn[`DTLB_WIDTH+`VPN_W-1:`VPN_W];
    assign w_index = upd_vpn[`DTLB_WIDTH+`VPN_W-1:`VPN_W];

    // Lookup
    always_comb begin
        hit       = 1'b0;
        hit_pte   = pte_q[r_index];
        hit_super = super_q[r_index];
        if (valid_q[r_index] && (vpn1_q[r_index] == lk_vpn1)) begin
            // A superpage covers every VPN[0]
            if (super_q[r_index] || (vpn0_q[r_index] == lk_vpn0)) begin
                hit = 1'b1;
            end
        end
    end

    // Valid bits, flush wins over a refill in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tlb_flush) begin
            valid_q <= '0;
        end else if (tlb_update) begin
            valid_q[w_index] <= 1'b1;
        end
    end

    // Entry payload, only meaningful behind its valid bit
    always_ff @(posedge clk) begin
        if (tlb_update && !tlb_flush) begin
            vpn1_q[w_index]  <= upd_vpn[2*`VPN_W-1:`VPN_W];
            vpn0_q[w_index]  <= upd_vpn[`VPN_W-1:0];
            super_q[w_index] <= upd_super;
            pte_q[w_index]   <= upd_pte;
        end
    end

endmodule

// File: hdl/satp_regs.sv
// satp register of the data MMU and the TLB flush pulse.
`timescale 1ns/100ps
`include "mmu_config.svh"

module satp_regs
    import mmu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        satp_we,
    input  logic [31:0] satp_wdata,
    input  logic        sfence,
    output logic        xlate_en,
    output ppn_t        root_ppn,
    output logic        tlb_flush
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Bare mode with a zero root after reset
            xlate_en  <= 1'b0;
            root_ppn  <= '0;
            tlb_flush <= 1'b0;
        end else begin
            // New address space or explicit fence, drop all cached mappings
            tlb_flush <= satp_we | sfence;
            if (satp_we) begin
                // Bit 31 is the Sv32 mode bit
                xlate_en <= satp_wdata[31];
                root_ppn <= satp_wdata[`PPN_W-1:0];
            end
        end
    end

endmodule

// File: common/mmu_pkg.sv
// Types shared by the data MMU blocks and the testbench.
// Modules take them with a wildcard import in their header.
`include "mmu_config.svh"

package mmu_pkg;

    // Raw 32-bit Sv32 page-table entry
    // Flags and PPN are picked out with the PTE_* positions
    typedef logic [31:0] pte_t;

    // Physical page number, upper PPN bits dropped
    typedef logic [`PPN_W-1:0] ppn_t;

    // Page-table walker states
    // Literals carry a prefix so both FSMs can share the package
    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_L1_REQ,
        PTW_L1_WAIT,
        PTW_L0_REQ,
        PTW_L0_WAIT,
        PTW_DONE
    } ptw_state_e;

    // Request sequencer states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_WALK,
        CTRL_RESP
    } ctrl_state_e;

endpackage

// File: common/mmu_config.svh
// Sizes, address fields and PTE bit positions of the Sv32 data MMU.
// Included by the package, the RTL and the testbench.
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// TLB geometry
`define DTLB_ENTRIES 16
`define DTLB_WIDTH 4

// One Sv32 VPN field
`define VPN_W 10

// PPN kept after truncation to a 32-bit physical space
`define PPN_W 20

// Page offset
`define PAGE_OFS_W 12

// PTE flag positions
`define PTE_V 0
`define PTE_R 1
`define PTE_W 2
`define PTE_X 3

// First bit of the PPN field in a PTE
`define PTE_PPN_LSB 10

`endif
